// File: common/riscv_settings.svh
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// Data and address width
`define RV_XLEN 32

// Shared memory depth in words
`define RV_MEM_WORDS 1024

// Address of the first fetch
`define RV_RESET_PC 32'h0000_0000

`endif

// File: common/riscv_pkg.sv
`include "riscv_settings.svh"

package riscv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // ALU operations
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        PASS_B
    } alu_op_e;

    // Multicycle sequencing states
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } core_state_e;

    // Decoder output, held stable from DECODE through WRITEBACK
    typedef struct packed {
        opcode_e             opcode;
        alu_op_e             alu_op;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] imm;
        logic                uses_imm;
        logic                writes_rd;
        logic                is_load;
        logic                is_store;
        logic                is_branch;
        logic                is_bne;
        logic                is_jal;
        logic                is_halt;
        logic                is_illegal;
    } decoded_instr_t;

endpackage

// File: common/wb_pkg.sv
`include "riscv_settings.svh"

package wb_pkg;

    // Master to slave signals of a classic Wishbone cycle
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`RV_XLEN-1:0]   adr;
        logic [`RV_XLEN-1:0]   dat;
        logic [`RV_XLEN/8-1:0] sel;
    } wb_req_t;

    // Slave to master signals
    typedef struct packed {
        logic                ack;
        logic [`RV_XLEN-1:0] dat;
    } wb_rsp_t;

    // Owner of the shared memory
    typedef enum logic [1:0] {
        NONE,
        HOST,
        DATA,
        FETCH
    } grant_e;

endpackage

// File: core/riscv_decoder.sv
`timescale 1ns/1ps

module riscv_decoder (
    input  logic [31:0]               instr,
    output riscv_pkg::decoded_instr_t dec
);
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Immediate formats, all sign-extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        dec.opcode = riscv_pkg::opcode_e'(instr[6:0]);
        dec.alu_op = riscv_pkg::ADD;
        dec.rd     = instr[11:7];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];

        case (instr[6:0])
            riscv_pkg::LUI: begin
                // rd = imm, ALU just forwards operand B
                dec.imm       = imm_u;
                dec.alu_op    = riscv_pkg::PASS_B;
                dec.uses_imm  = 1'b1;
                dec.writes_rd = 1'b1;
            end
            riscv_pkg::OP_IMM: begin
                // Only ADDI
                dec.imm        = imm_i;
                dec.uses_imm   = 1'b1;
                dec.writes_rd  = 1'b1;
                dec.is_illegal = (funct3 != 3'b000);
            end
            riscv_pkg::OP: begin
                dec.writes_rd = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec.alu_op = riscv_pkg::ADD;
                    {7'b0100000, 3'b000}: dec.alu_op = riscv_pkg::SUB;
                    {7'b0000000, 3'b111}: dec.alu_op = riscv_pkg::AND;
                    {7'b0000000, 3'b110}: dec.alu_op = riscv_pkg::OR;
                    {7'b0000000, 3'b100}: dec.alu_op = riscv_pkg::XOR;
                    {7'b0000000, 3'b010}: dec.alu_op = riscv_pkg::SLT;
                    default:              dec.is_illegal = 1'b1;
                endcase
            end
            riscv_pkg::LOAD: begin
                // Word loads only, address = rs1 + imm
                dec.imm        = imm_i;
                dec.uses_imm   = 1'b1;
                dec.writes_rd  = 1'b1;
                dec.is_load    = 1'b1;
                dec.is_illegal = (funct3 != 3'b010);
            end
            riscv_pkg::STORE: begin
                dec.imm        = imm_s;
                dec.uses_imm   = 1'b1;
                dec.is_store   = 1'b1;
                dec.is_illegal = (funct3 != 3'b010);
            end
            riscv_pkg::BRANCH: begin
                // BEQ and BNE, compare done in the core
                dec.imm        = imm_b;
                dec.alu_op     = riscv_pkg::SUB;
                dec.is_branch  = 1'b1;
                dec.is_bne     = (funct3 == 3'b001);
                dec.is_illegal = (funct3[2:1] != 2'b00);
            end
            riscv_pkg::JAL: begin
                dec.imm       = imm_j;
                dec.writes_rd = 1'b1;
                dec.is_jal    = 1'b1;
            end
            riscv_pkg::SYSTEM: begin
                // EBREAK is the one accepted encoding
                dec.is_halt    = (instr == 32'h0010_0073);
                dec.is_illegal = (instr != 32'h0010_0073);
            end
            default: dec.is_illegal = 1'b1;
        endcase
    end

endmodule

// File: core/riscv_core.sv
`timescale 1ns/1ps
`include "riscv_settings.svh"

module riscv_core (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            hlt_in,
    input  logic            step_in,
    output wb_pkg::wb_req_t ibus_req,
    input  wb_pkg::wb_rsp_t ibus_rsp,
    output wb_pkg::wb_req_t dbus_req,
    input  wb_pkg::wb_rsp_t dbus_rsp,
    output logic            retire,
    output logic            halted
);
    riscv_pkg::core_state_e    state;
    riscv_pkg::core_state_e    state_next;
    riscv_pkg::decoded_instr_t dec;

    // Architectural state
    logic [`RV_XLEN-1:0] pc;
    logic [31:0]         ir;
    logic [`RV_XLEN-1:0] rf [32];

    // Stage results, held until the next stage consumes them
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_out;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] target;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] wb_data;
    logic                take;

    // Bus and step control
    logic ibus_cyc;
    logic dbus_cyc;
    logic step_q;
    logic step_rise;
    logic fetch_start;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            riscv_pkg::FETCH: begin
                if (ibus_cyc && ibus_rsp.ack) state_next = riscv_pkg::DECODE;
            end
            riscv_pkg::DECODE: begin
                // EBREAK and bad encodings both park the core
                if (dec.is_illegal || dec.is_halt) state_next = riscv_pkg::HALTED;
                else state_next = riscv_pkg::EXECUTE;
            end
            riscv_pkg::EXECUTE: begin
                if (dec.is_load || dec.is_store) state_next = riscv_pkg::MEMORY;
                else state_next = riscv_pkg::WRITEBACK;
            end
            riscv_pkg::MEMORY: begin
                if (dbus_cyc && dbus_rsp.ack) state_next = riscv_pkg::WRITEBACK;
            end
            riscv_pkg::WRITEBACK: state_next = riscv_pkg::FETCH;
            riscv_pkg::HALTED:    state_next = riscv_pkg::HALTED;
            default:              state_next = riscv_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= riscv_pkg::FETCH;
        end else begin
            state <= state_next;
        end
    end

    assign retire = (state == riscv_pkg::WRITEBACK);
    assign halted = (state == riscv_pkg::HALTED);

    ////////////////////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////////////////////

    // Rising edge of the step pin
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            step_q <= 1'b0;
        end else begin
            step_q <= step_in;
        end
    end

    assign step_rise = step_in && !step_q;

    // Halt only blocks a fetch that has not started yet
    assign fetch_start = (state == riscv_pkg::FETCH) && !ibus_cyc && (!hlt_in || step_rise);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ibus_cyc <= 1'b0;
        end else if (fetch_start) begin
            ibus_cyc <= 1'b1;
        end else if (ibus_cyc && ibus_rsp.ack) begin
            ibus_cyc <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (ibus_cyc && ibus_rsp.ack) begin
            ir <= ibus_rsp.dat;
        end
    end

    // Read-only port, address is the PC
    always_comb begin
        ibus_req     = '0;
        ibus_req.cyc = ibus_cyc;
        ibus_req.stb = ibus_cyc;
        ibus_req.adr = pc;
        ibus_req.sel = '1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    riscv_decoder i_decoder (
        .instr (ir),
        .dec   (dec)
    );

    // Register file read, x0 forced to zero
    always_ff @(posedge clk_in) begin
        if (state == riscv_pkg::DECODE) begin
            rs1_val <= (dec.rs1 == 5'd0) ? '0 : rf[dec.rs1];
            rs2_val <= (dec.rs2 == 5'd0) ? '0 : rf[dec.rs2];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////////////////////

    assign alu_b = dec.uses_imm ? dec.imm : rs2_val;

    always_comb begin
        case (dec.alu_op)
            riscv_pkg::ADD:    alu_out = rs1_val + alu_b;
            riscv_pkg::SUB:    alu_out = rs1_val - alu_b;
            riscv_pkg::AND:    alu_out = rs1_val & alu_b;
            riscv_pkg::OR:     alu_out = rs1_val | alu_b;
            riscv_pkg::XOR:    alu_out = rs1_val ^ alu_b;
            riscv_pkg::SLT:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_val) < $signed(alu_b)};
            riscv_pkg::PASS_B: alu_out = alu_b;
            default:           alu_out = '0;
        endcase
    end

    // Branch decision and target, JAL always taken
    always_ff @(posedge clk_in) begin
        if (state == riscv_pkg::EXECUTE) begin
            alu_res <= alu_out;
            take    <= dec.is_jal || (dec.is_branch && ((rs1_val == rs2_val) != dec.is_bne));
            target  <= pc + dec.imm;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            dbus_cyc <= 1'b0;
        end else if (state == riscv_pkg::EXECUTE && (dec.is_load || dec.is_store)) begin
            dbus_cyc <= 1'b1;
        end else if (dbus_cyc && dbus_rsp.ack) begin
            dbus_cyc <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (dbus_cyc && dbus_rsp.ack) begin
            load_data <= dbus_rsp.dat;
        end
    end

    // Address from the ALU, store data straight from rs2
    always_comb begin
        dbus_req     = '0;
        dbus_req.cyc = dbus_cyc;
        dbus_req.stb = dbus_cyc;
        dbus_req.we  = dec.is_store;
        dbus_req.adr = alu_res;
        dbus_req.dat = rs2_val;
        dbus_req.sel = '1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////////////////////////////////////////

    assign pc_plus4 = pc + `RV_XLEN'(4);

    // Link address for JAL, loaded word, or ALU result
    always_comb begin
        if (dec.is_jal) wb_data = pc_plus4;
        else if (dec.is_load) wb_data = load_data;
        else wb_data = alu_res;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pc <= `RV_RESET_PC;
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (state == riscv_pkg::WRITEBACK) begin
            if (dec.writes_rd && dec.rd != 5'd0) begin
                rf[dec.rd] <= wb_data;
            end
            pc <= take ? target : pc_plus4;
        end
    end

endmodule

// File: hdl/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
    input  logic            clk_in,
    input  logic            rst_in,
    input  wb_pkg::wb_req_t host_req,
    input  wb_pkg::wb_req_t data_req,
    input  wb_pkg::wb_req_t fetch_req,
    output wb_pkg::wb_rsp_t host_rsp,
    output wb_pkg::wb_rsp_t data_rsp,
    output wb_pkg::wb_rsp_t fetch_rsp,
    output wb_pkg::wb_req_t slave_req,
    input  wb_pkg::wb_rsp_t slave_rsp
);
    wb_pkg::grant_e grant;
    wb_pkg::grant_e grant_next;

    // New grant only from idle, priority host > data > fetch
    always_comb begin
        grant_next = grant;
        case (grant)
            wb_pkg::NONE: begin
                if (host_req.cyc) grant_next = wb_pkg::HOST;
                else if (data_req.cyc) grant_next = wb_pkg::DATA;
                else if (fetch_req.cyc) grant_next = wb_pkg::FETCH;
            end
            // Hold until the owner drops cyc
            wb_pkg::HOST:  if (!host_req.cyc) grant_next = wb_pkg::NONE;
            wb_pkg::DATA:  if (!data_req.cyc) grant_next = wb_pkg::NONE;
            wb_pkg::FETCH: if (!fetch_req.cyc) grant_next = wb_pkg::NONE;
            default:       grant_next = wb_pkg::NONE;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            grant <= wb_pkg::NONE;
        end else begin
            grant <= grant_next;
        end
    end

    // Request mux, idle slave sees cyc low
    always_comb begin
        case (grant)
            wb_pkg::HOST:  slave_req = host_req;
            wb_pkg::DATA:  slave_req = data_req;
            wb_pkg::FETCH: slave_req = fetch_req;
            default:       slave_req = '0;
        endcase
    end

    // Read data fans out, ack only to the owner
    always_comb begin
        host_rsp      = slave_rsp;
        data_rsp      = slave_rsp;
        fetch_rsp     = slave_rsp;
        host_rsp.ack  = slave_rsp.ack && (grant == wb_pkg::HOST);
        data_rsp.ack  = slave_rsp.ack && (grant == wb_pkg::DATA);
        fetch_rsp.ack = slave_rsp.ack && (grant == wb_pkg::FETCH);
    end

endmodule

// File: hdl/wb_ram.sv
`timescale 1ns/1ps
`include "riscv_settings.svh"

module wb_ram (
    input  logic            clk_in,
    input  logic            rst_in,
    input  wb_pkg::wb_req_t req,
    output wb_pkg::wb_rsp_t rsp
);
    localparam int ADDR_BITS = $clog2(`RV_MEM_WORDS);
    localparam int LANES     = `RV_XLEN / 8;

    logic [`RV_XLEN-1:0] mem [`RV_MEM_WORDS];
    logic [ADDR_BITS-1:0] word_idx;
    logic [`RV_XLEN-1:0]  rd_q;
    logic                 ack_q;
    logic                 access;

    // Byte address bits above the depth are dropped
    assign word_idx = req.adr[ADDR_BITS+1:2];

    // No new access while the ack of the last one is out
    assign access = req.cyc && req.stb && !ack_q;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Byte-lane write, old word captured as read data
    always_ff @(posedge clk_in) begin
        if (access) begin
            if (req.we) begin
                for (int b = 0; b < LANES; b++) begin
                    if (req.sel[b]) mem[word_idx][8*b +: 8] <= req.dat[8*b +: 8];
                end
            end
            rd_q <= mem[word_idx];
        end
    end

    assign rsp.ack = ack_q;
    assign rsp.dat = rd_q;

endmodule

// File: hdl/riscv_soc.sv
`timescale 1ns/1ps

module riscv_soc (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            hlt_in,
    input  logic            step_in,
    input  wb_pkg::wb_req_t host_req,
    output wb_pkg::wb_rsp_t host_rsp,
    output logic            retire,
    output logic            halted
);
    // Core master ports
    wb_pkg::wb_req_t ibus_req;
    wb_pkg::wb_rsp_t ibus_rsp;
    wb_pkg::wb_req_t dbus_req;
    wb_pkg::wb_rsp_t dbus_rsp;

    // Arbiter to memory
    wb_pkg::wb_req_t ram_req;
    wb_pkg::wb_rsp_t ram_rsp;

    riscv_core i_core (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .hlt_in   (hlt_in),
        .step_in  (step_in),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .dbus_req (dbus_req),
        .dbus_rsp (dbus_rsp),
        .retire   (retire),
        .halted   (halted)
    );

    wb_arbiter i_arbiter (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .host_req  (host_req),
        .data_req  (dbus_req),
        .fetch_req (ibus_req),
        .host_rsp  (host_rsp),
        .data_rsp  (dbus_rsp),
        .fetch_rsp (ibus_rsp),
        .slave_req (ram_req),
        .slave_rsp (ram_rsp)
    );

    wb_ram i_ram (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .req    (ram_req),
        .rsp    (ram_rsp)
    );

endmodule

// File: sim/tb_riscv_soc.sv
`timescale 1ns/1ps

module tb_riscv_soc;

    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 2000;
    // Quiet window after a step
    localparam int STEP_QUIET = 16;

    logic            clk_in;
    logic            rst_in;
    logic            hlt_in;
    logic            step_in;
    wb_pkg::wb_req_t host_req;
    wb_pkg::wb_rsp_t host_rsp;
    logic            retire;
    logic            halted;

    // Run bookkeeping
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_errors;
    logic        timed_out;
    string       test_name;
    logic [31:0] wr_seed;
    logic [31:0] rd_seed;

    riscv_soc i_dut (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .hlt_in   (hlt_in),
        .step_in  (step_in),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .retire   (retire),
        .halted   (halted)
    );

    // 4 ns clock
    always #2 clk_in = ~clk_in;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // 32-bit xorshift, 13/17/5
    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout at %0d ns: %s", $time, what);
        timed_out = 1'b1;
        errors++;
    endtask

    task automatic check_value(input string sig, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got == exp) else begin
            $display("ERR %0d ns %s expected %08h actual %08h", $time, sig, exp, got);
            errors++;
        end
    endtask

    // Core parked in halt, bus idle
    task automatic reset_dut();
        hlt_in   = 1'b1;
        step_in  = 1'b0;
        host_req = '0;
        rst_in   = 1'b1;
        repeat (8) @(negedge clk_in);
        rst_in = 1'b0;
        @(negedge clk_in);
    endtask

    // One classic cycle on the host port, held until ack
    task automatic host_access(input logic we, input logic [31:0] adr,
                               input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        n            = 0;
        rdat         = '0;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = adr;
        host_req.dat = wdat;
        host_req.sel = '1;
        @(negedge clk_in);
        while (!host_rsp.ack && n < WAIT_LIMIT) begin
            @(negedge clk_in);
            n++;
        end
        if (host_rsp.ack) begin
            rdat = host_rsp.dat;
        end else begin
            report_timeout($sformatf("host cycle to %08h never acknowledged", adr));
        end
        // Drop cyc after the ack cycle, bus idle for one cycle
        host_req = '0;
        @(negedge clk_in);
    endtask

    task automatic release_and_wait();
        int n;
        n      = 0;
        hlt_in = 1'b0;
        while (!halted && n < WAIT_LIMIT) begin
            @(negedge clk_in);
            n++;
        end
        if (!halted) report_timeout("core did not reach halted after release");
    endtask

    // Single rising edge on step, then exactly one retire expected
    task automatic step_once();
        int n;
        int extra;
        n       = 0;
        extra   = 0;
        step_in = 1'b1;
        @(negedge clk_in);
        step_in = 1'b0;
        while (!retire && n < WAIT_LIMIT) begin
            @(negedge clk_in);
            n++;
        end
        if (!retire) begin
            report_timeout("no retire pulse after a step");
        end else begin
            for (int k = 0; k < STEP_QUIET; k++) begin
                @(negedge clk_in);
                if (retire) extra++;
            end
            checks++;
            assert (extra == 0) else begin
                $display("a single step retired %0d extra instructions", extra);
                errors++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Command interpreter
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          fd;
        int          code;
        string       line;
        string       cmd;
        string       name;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] got;
        clk_in       = 1'b0;
        rst_in       = 1'b1;
        hlt_in       = 1'b1;
        step_in      = 1'b0;
        host_req     = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        timed_out    = 1'b0;
        test_name    = "none";
        wr_seed      = 32'd27;
        rd_seed      = 32'd27;
        reset_dut();

        fd = $fopen("sim/riscv_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/riscv_tests.txt");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                if ($fgets(line, fd) == 0) line = "";
                cmd  = "";
                code = $sscanf(line, "%s", cmd);
                if (cmd == "T") begin
                    code        = $sscanf(line, "%s %s", cmd, name);
                    test_name   = name;
                    test_errors = errors;
                    tests_run++;
                    reset_dut();
                end else if (cmd == "W") begin
                    code = $sscanf(line, "%s %h %h", cmd, a, d);
                    host_access(1'b1, a, d, got);
                end else if (cmd == "R") begin
                    code = $sscanf(line, "%s %h %h", cmd, a, d);
                    host_access(1'b0, a, '0, got);
                    if (!timed_out) check_value($sformatf("mem[%03h]", a), d, got);
                end else if (cmd == "X") begin
                    // Random write, stream one
                    code    = $sscanf(line, "%s %h", cmd, a);
                    wr_seed = next_random(wr_seed);
                    host_access(1'b1, a, wr_seed, got);
                end else if (cmd == "Y") begin
                    // Same sequence regenerated for the readback
                    code    = $sscanf(line, "%s %h", cmd, a);
                    rd_seed = next_random(rd_seed);
                    host_access(1'b0, a, '0, got);
                    if (!timed_out) check_value($sformatf("mem[%03h]", a), rd_seed, got);
                end else if (cmd == "H") begin
                    code   = $sscanf(line, "%s %h", cmd, d);
                    hlt_in = d[0];
                    @(negedge clk_in);
                end else if (cmd == "G") begin
                    release_and_wait();
                end else if (cmd == "S") begin
                    step_once();
                end else if (cmd == "E") begin
                    if (errors == test_errors) begin
                        $display("test %s: ok", test_name);
                    end else begin
                        $display("test %s: failed, %0d errors", test_name,
                                 errors - test_errors);
                        tests_failed++;
                    end
                end else if (cmd != "" && cmd != "#") begin
                    $display("unknown command in tests file: %s", cmd);
                    errors++;
                end
            end
            $fclose(fd);
        end

        if (timed_out) begin
            $display("test %s: aborted by a timeout", test_name);
            tests_failed++;
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sim/riscv_tests.txt
# Columns: command, then hex operands. T name | W addr data | R addr expected
# X addr (random write) | Y addr (random readback) | H 0/1 | G | S | E
T host_mem
W 400 12345678
W 404 DEADBEEF
W FFC A5A55A5A
X 408
X 40C
R 400 12345678
R 404 DEADBEEF
R FFC A5A55A5A
Y 408
Y 40C
E
# lui addi add sub and or xor slt, results stored at 400..418
T arith
W 00 123450B7
W 04 67808093
W 08 FFF00113
W 0C 002081B3
W 10 40208233
W 14 0F000313
W 18 0060F2B3
W 1C 0060E3B3
W 20 0060C433
W 24 001124B3
W 28 0020A533
W 2C 40302023
W 30 40A02223
W 34 40402423
W 38 40502623
W 3C 40702823
W 40 40802A23
W 44 40902C23
W 48 00100073
G
R 400 12345677
R 404 00000000
R 408 12345679
R 40C 00000070
R 410 123456F8
R 414 12345688
R 418 00000001
E
# copy 500/504 to 600/604, sum to 608, reload sum and store to 60C
T load_store
W 500 00001111
W 504 00002222
W 00 50002083
W 04 50402103
W 08 60102023
W 0C 60202223
W 10 002081B3
W 14 60302423
W 18 60802203
W 1C 60402623
W 20 00100073
H 0
R 500 00001111
R 504 00002222
R 00 50002083
R 04 50402103
G
R 600 00001111
R 604 00002222
R 608 00003333
R 60C 00003333
E
# bne loop to 5, beq skips 704, jal skips 708, link stored at 70C
T control_flow
W 704 00000000
W 708 00000000
W 00 00000093
W 04 00500113
W 08 00108093
W 0C FE209EE3
W 10 70102023
W 14 00208463
W 18 70202223
W 1C 008001EF
W 20 70202423
W 24 70302623
W 28 00100073
G
R 700 00000005
R 704 00000000
R 708 00000000
R 70C 00000020
E
T halt_step
W 780 00000000
W 784 00000000
W 00 01100093
W 04 78102023
W 08 02200113
W 0C 78202223
W 10 00100073
S
S
R 780 00000011
R 784 00000000
S
R 784 00000000
G
R 784 00000022
E
# word at 08 has opcode 7F, store at 0C must not happen
T illegal
W 7C0 00000000
W 7C4 00000000
W 00 05500093
W 04 7C102023
W 08 FFFFFFFF
W 0C 7C102223
W 10 00100073
G
R 7C0 00000055
R 7C4 00000000
E

// File: tb.f
+incdir+common
common/riscv_pkg.sv
common/wb_pkg.sv
core/riscv_decoder.sv
core/riscv_core.sv
hdl/wb_arbiter.sv
hdl/wb_ram.sv
hdl/riscv_soc.sv
sim/tb_riscv_soc.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SoC testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --assert --timescale 1ns/1ps -f tb.f \
    --top-module tb_riscv_soc -Mdir "$BUILD" -o tb_riscv_soc
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD/tb_riscv_soc" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
